/* filelist.f */
design/prefetchPkg.sv
design/busPkg.sv
design/missFifo.sv
design/missRouter.sv
design/patternDetector.sv
design/prefetchIssuer.sv
design/prefetcherTop.sv
bench/prefetcher_checker.sv
bench/prefetcherTb.sv

/* Makefile */
TOP = prefetcherTb

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "All tests passed" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* bench/prefetcherTb.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetcherTb import prefetchPkg::*, busPkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_ROWS    = 6;
    localparam int MAX_MISSES  = 8;
    localparam int MAX_EXP     = 4;
    localparam int IDLE_CYCLES = 40;
    localparam int ROW_CYCLES  = 400;

    logic  clk = 1'b0;
    logic  rst;
    missT  miss;
    wbReqT wbReq;
    wbRspT wbRsp = '0;

    // Stimulus table, one entry per test.
    string rowName      [NUM_ROWS];
    int    rowMiss      [NUM_ROWS][MAX_MISSES];
    int    rowMissCount [NUM_ROWS];
    int    rowGap       [NUM_ROWS];
    int    rowResetAt   [NUM_ROWS];
    int    rowAckDelay  [NUM_ROWS];
    int    rowExp       [NUM_ROWS][MAX_EXP];
    int    rowExpCount  [NUM_ROWS];
    bit    rowAnyOrder  [NUM_ROWS];

    integer      seed = 32'hfe51_61f8;
    int          ackDelay = 0;
    int          curDelay = 1;
    int          stbCycles = 0;
    logic [31:0] reads [$];
    logic        weSeen [$];
    int          passCount;
    int          failCount;

    prefetcherTop uut (
        .clk  (clk),
        .rst  (rst),
        .miss (miss),
        .wbReq(wbReq),
        .wbRsp(wbRsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone slave model and read monitor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int pickDelay();
        if (ackDelay > 0) begin
            return ackDelay;
        end
        return 1 + ($unsigned($random(seed)) % 4);
    endfunction

    always @(negedge clk) begin
        if (rst || !wbReq.stb) begin
            wbRsp.ack <= 1'b0;
            stbCycles <= 0;
        end else if (!wbRsp.ack) begin
            if (stbCycles == 0) begin
                curDelay = pickDelay();
            end
            if (stbCycles + 1 >= curDelay) begin
                wbRsp.ack <= 1'b1;
            end
            stbCycles <= stbCycles + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst && wbReq.cyc && wbReq.stb && wbRsp.ack) begin
            reads.push_back(wbReq.adr);
            weSeen.push_back(wbReq.we);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table and row tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 64-byte lines on a byte-addressed bus.
    function automatic logic [31:0] lineToAdr(input int line);
        return 32'(line) << 6;
    endfunction

    task automatic setRow(input int r, input string name, input int missCount,
                          input int gap, input int resetAt, input int ackWait,
                          input int expCount, input bit anyOrder);
        rowName[r]      = name;
        rowMissCount[r] = missCount;
        rowGap[r]       = gap;
        rowResetAt[r]   = resetAt;
        rowAckDelay[r]  = ackWait;
        rowExpCount[r]  = expCount;
        rowAnyOrder[r]  = anyOrder;
    endtask

    task automatic loadTable();
        // Lane 1. After the match at 102 two fresh misses are needed.
        setRow(0, "ascending stream", 5, 4, -1, 0, 2, 1'b0);
        rowMiss[0] = '{100, 101, 102, 103, 104, 0, 0, 0};
        rowExp[0]  = '{103, 105, 0, 0};
        setRow(1, "descending stream", 3, 4, -1, 0, 1, 1'b0);
        rowMiss[1] = '{200, 199, 198, 0, 0, 0, 0, 0};
        rowExp[1]  = '{197, 0, 0, 0};
        // Scattered lines in lane 0, a stride of two in lane 2.
        setRow(2, "no pattern", 7, 2, -1, 0, 0, 1'b0);
        rowMiss[2] = '{300, 305, 302, 310, 400, 402, 404, 0};
        rowExp[2]  = '{0, 0, 0, 0};
        setRow(3, "parallel lanes", 6, 2, -1, 0, 2, 1'b1);
        rowMiss[3] = '{74, 138, 75, 139, 76, 140, 0, 0};
        rowExp[3]  = '{77, 141, 0, 0};
        // Lanes 1 and 2 carry on from the streams above, lane 0 starts fresh.
        setRow(4, "slow ack", 7, 1, -1, 4, 3, 1'b1);
        rowMiss[4] = '{77, 141, 520, 78, 142, 521, 522, 0};
        rowExp[4]  = '{79, 143, 523, 0};
        // Reset lands between 501 and 502.
        setRow(5, "mid-test reset", 5, 4, 2, 0, 1, 1'b0);
        rowMiss[5] = '{500, 501, 502, 503, 504, 0, 0, 0};
        rowExp[5]  = '{505, 0, 0, 0};
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic sendMiss(input int line);
        miss = '{valid: 1'b1, addr: lineAddrT'(line)};
        @(negedge clk);
        miss.valid = 1'b0;
    endtask

    task automatic waitBusIdle();
        int quiet;
        quiet = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge clk);
            if (wbReq.cyc) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic runRow(input int r);
        reads.delete();
        weSeen.delete();
        ackDelay = rowAckDelay[r];
        for (int m = 0; m < rowMissCount[r]; m++) begin
            if (m == rowResetAt[r]) begin
                applyReset();
            end
            sendMiss(rowMiss[r][m]);
            repeat (rowGap[r] - 1) @(negedge clk);
        end
        waitBusIdle();
    endtask

    task automatic checkRow(input int r);
        logic [31:0] want [$];
        logic [31:0] got [$];
        int          errs;
        errs = 0;
        got  = reads;
        for (int e = 0; e < rowExpCount[r]; e++) begin
            want.push_back(lineToAdr(rowExp[r][e]));
        end
        // Arrival order across lanes is not fixed.
        if (rowAnyOrder[r]) begin
            want.sort();
            got.sort();
        end
        if (got.size() != want.size()) begin
            $display("%s: expected %0d bus reads, the bus carried %0d",
                     rowName[r], want.size(), got.size());
            errs++;
        end
        for (int e = 0; e < want.size() && e < got.size(); e++) begin
            if (got[e] !== want[e]) begin
                $display("FAIL %s adr: expected %08h, got %08h", rowName[r], want[e], got[e]);
                errs++;
            end
        end
        for (int e = 0; e < weSeen.size(); e++) begin
            if (weSeen[e] !== 1'b0) begin
                $display("FAIL %s we: expected 0, got %h", rowName[r], weSeen[e]);
                errs++;
            end
        end
        if (errs == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("Test %0d %s: %s", r, rowName[r], (errs == 0) ? "passed" : "failed");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst       = 1'b1;
        miss      = '0;
        passCount = 0;
        failCount = 0;
        loadTable();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
            checkRow(r);
        end
        $display("Summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles", NUM_ROWS * ROW_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/prefetcher_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetcherChecker import prefetchPkg::*, busPkg::*; (
    input logic    clk,
    input logic    rst,
    input wbReqT   wbReq,
    input wbRspT   wbRsp,
    input patternT lanePattern [NUM_LANES]
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic, master side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
        wbReq.stb |-> wbReq.cyc)
        else $error("stb high while cyc is low");

    // Request held until the slave acks.
    adrHeld: assert property (@(posedge clk) disable iff (rst)
        (wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr)))
        else $error("request changed before ack, adr %h", wbReq.adr);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern pulses, one cycle wide per lane.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        singlePulse: assert property (@(posedge clk) disable iff (rst)
            lanePattern[i].valid |=> !lanePattern[i].valid)
            else $error("lane %0d pattern valid for more than one cycle", i);
    end

endmodule

bind prefetcherTop prefetcherChecker protocolCheck (
    .clk        (clk),
    .rst        (rst),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .lanePattern(lanePattern)
);

`default_nettype wire

/* design/prefetcherTop.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetcherTop import prefetchPkg::*, busPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  missT  miss,
    output wbReqT wbReq,
    input  wbRspT wbRsp
);

    missT    laneMiss [NUM_LANES];
    patternT lanePattern [NUM_LANES];

    missRouter router (
        .clk     (clk),
        .rst     (rst),
        .miss    (miss),
        .laneMiss(laneMiss)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Detector lanes, one per region.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        patternDetector detector (
            .clk        (clk),
            .rst        (rst),
            .laneMiss   (laneMiss[i]),
            .lanePattern(lanePattern[i])
        );
    end

    prefetchIssuer issuer (
        .clk        (clk),
        .rst        (rst),
        .lanePattern(lanePattern),
        .wbReq      (wbReq),
        .wbRsp      (wbRsp)
    );

endmodule

`default_nettype wire

/* design/prefetchIssuer.sv */
`timescale 1ns/1ps
`default_nettype none

module prefetchIssuer import prefetchPkg::*, busPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  patternT lanePattern [NUM_LANES],
    output wbReqT   wbReq,
    input  wbRspT   wbRsp
);

    patternT  pend [NUM_LANES];
    laneIdxT  lastLane;
    laneIdxT  pick;
    logic     pickValid;
    logic     grant;
    busStateE state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick, starting after the last lane served.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        laneIdxT cand;
        pick      = lastLane;
        pickValid = 1'b0;
        for (int k = NUM_LANES; k > 0; k--) begin
            cand = laneIdxT'((int'(lastLane) + k) % NUM_LANES);
            if (pend[cand].valid) begin
                pick      = cand;
                pickValid = 1'b1;
            end
        end
    end

    assign grant = (state == BUS_IDLE) && pickValid;

    always_ff @(posedge clk) begin
        // Reads only.
        wbReq.we <= 1'b0;
        if (grant) begin
            wbReq.adr <= {pend[pick].addr, {(WB_ADR_BITS - LINE_ADDR_BITS){1'b0}}};
        end

        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                pend[i].valid <= 1'b0;
            end
            lastLane  <= laneIdxT'(NUM_LANES - 1);
            state     <= BUS_IDLE;
            wbReq.cyc <= 1'b0;
            wbReq.stb <= 1'b0;
        end else begin
            // A fresh pattern overwrites the slot, even the one being granted.
            for (int i = 0; i < NUM_LANES; i++) begin
                if (grant && (pick == laneIdxT'(i))) begin
                    pend[i].valid <= 1'b0;
                end
                if (lanePattern[i].valid) begin
                    pend[i] <= lanePattern[i];
                end
            end

            case (state)
                BUS_IDLE: begin
                    if (pickValid) begin
                        wbReq.cyc <= 1'b1;
                        wbReq.stb <= 1'b1;
                        lastLane  <= pick;
                        state     <= BUS_WAIT;
                    end
                end
                BUS_WAIT: begin
                    // Hold the request until the slave acks.
                    if (wbRsp.ack) begin
                        wbReq.cyc <= 1'b0;
                        wbReq.stb <= 1'b0;
                        state     <= BUS_IDLE;
                    end
                end
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/patternDetector.sv */
`timescale 1ns/1ps
`default_nettype none

module patternDetector import prefetchPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  missT    laneMiss,
    output patternT lanePattern
);

    typedef logic [$clog2(HIST_DEPTH)-1:0] histIdxT;

    typedef struct packed {
        logic    valid;
        histIdxT idx;
    } scanT;

    missT     queued;
    logic     take;
    logic     lastStep;

    // Entry 0 is the newest miss, the one under scan.
    missT     hist [HIST_DEPTH];
    missT     histNext [HIST_DEPTH];
    scanT     scan;

    missT     cur;
    lineAddrT base;
    lineAddrT plus1;
    lineAddrT plus2;
    lineAddrT minus1;
    lineAddrT minus2;
    logic     upHit;
    logic     downHit;
    scanT     upPair;
    scanT     downPair;
    logic     match;
    histIdxT  pairIdx;

    missFifo queue (
        .clk (clk),
        .rst (rst),
        .in  (laneMiss),
        .take(take),
        .out (queued)
    );

    assign lastStep = scan.valid && (scan.idx == histIdxT'(HIST_DEPTH - 1));
    assign take     = queued.valid && (!scan.valid || lastStep);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stride scan, one older entry per cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        base   = hist[0].addr;
        plus1  = base + 1'b1;
        plus2  = base + 2'd2;
        minus1 = base - 1'b1;
        minus2 = base - 2'd2;
        cur    = hist[scan.idx];

        upHit   = scan.valid && cur.valid && (cur.addr == minus1);
        downHit = scan.valid && cur.valid && (cur.addr == plus1);

        // Lowest index wins, so the nearest partner is taken.
        upPair   = '0;
        downPair = '0;
        for (int i = HIST_DEPTH - 1; i > 0; i--) begin
            if (hist[i].valid && (hist[i].addr == minus2)) begin
                upPair = '{valid: 1'b1, idx: histIdxT'(i)};
            end
            if (hist[i].valid && (hist[i].addr == plus2)) begin
                downPair = '{valid: 1'b1, idx: histIdxT'(i)};
            end
        end

        match   = (upHit && upPair.valid) || (downHit && downPair.valid);
        pairIdx = upHit ? upPair.idx : downPair.idx;

        // Matched older entries drop out.
        for (int i = 0; i < HIST_DEPTH; i++) begin
            histNext[i] = hist[i];
        end
        if (match) begin
            histNext[scan.idx].valid = 1'b0;
            histNext[pairIdx].valid  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        lanePattern.stride <= upHit ? STRIDE_UP : STRIDE_DOWN;
        lanePattern.addr   <= upHit ? plus1 : minus1;
        if (rst) begin
            for (int i = 0; i < HIST_DEPTH; i++) begin
                hist[i].valid <= 1'b0;
            end
            scan              <= '0;
            lanePattern.valid <= 1'b0;
        end else begin
            lanePattern.valid <= match;
            if (take) begin
                hist[0] <= queued;
                for (int i = 1; i < HIST_DEPTH; i++) begin
                    hist[i] <= histNext[i-1];
                end
                scan <= '{valid: 1'b1, idx: histIdxT'(1)};
            end else begin
                for (int i = 0; i < HIST_DEPTH; i++) begin
                    hist[i] <= histNext[i];
                end
                if (match || lastStep) begin
                    scan.valid <= 1'b0;
                end else if (scan.valid) begin
                    scan.idx <= scan.idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/missRouter.sv */
`timescale 1ns/1ps
`default_nettype none

module missRouter import prefetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  missT miss,
    output missT laneMiss [NUM_LANES]
);

    laneIdxT laneSel;

    // Region bits above the line offset within a region.
    assign laneSel = miss.addr[LANE_SEL_LSB +: $bits(laneIdxT)];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One registered copy per lane, only the selected one valid.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laneMiss[i].addr <= miss.addr;
            if (rst) begin
                laneMiss[i].valid <= 1'b0;
            end else begin
                laneMiss[i].valid <= miss.valid && (laneSel == laneIdxT'(i));
            end
        end
    end

endmodule

`default_nettype wire

/* design/missFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module missFifo import prefetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  missT in,
    input  logic take,
    output missT out
);

    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptrT;
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] countT;

    lineAddrT mem [QUEUE_DEPTH];
    ptrT      wrPtr;
    ptrT      rdPtr;
    countT    count;
    logic     push;
    logic     pop;

    // A miss that finds the queue full is lost.
    assign push = in.valid && (count != countT'(QUEUE_DEPTH));
    assign pop  = take && (count != '0);

    assign out = '{valid: (count != '0), addr: mem[rdPtr]};

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= in.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrT'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrT'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/busPkg.sv */
`default_nettype none

package busPkg;

    localparam int WB_ADR_BITS = 32;
    localparam int WB_DAT_BITS = 32;

    // Master to slave, Wishbone classic.
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WB_ADR_BITS-1:0] adr;
    } wbReqT;

    // Slave to master.
    typedef struct packed {
        logic                   ack;
        logic [WB_DAT_BITS-1:0] dat;
    } wbRspT;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } busStateE;

endpackage

`default_nettype wire

/* design/prefetchPkg.sv */
`default_nettype none

package prefetchPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int LINE_ADDR_BITS = 26;
    localparam int NUM_LANES = 4;

    // Region field that picks a lane, 64 lines per region.
    localparam int LANE_SEL_LSB = 6;

    localparam int HIST_DEPTH = 4;
    localparam int QUEUE_DEPTH = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prefetch data types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [LINE_ADDR_BITS-1:0] lineAddrT;

    typedef enum logic {
        STRIDE_UP,
        STRIDE_DOWN
    } strideE;

    typedef struct packed {
        logic     valid;
        lineAddrT addr;
    } missT;

    // Addr is the predicted line.
    typedef struct packed {
        logic     valid;
        strideE   stride;
        lineAddrT addr;
    } patternT;

    typedef logic [$clog2(NUM_LANES)-1:0] laneIdxT;

endpackage

`default_nettype wire
